// File: Makefile
# Verilator build and run of the branch prediction testbench
VERILATOR ?= verilator
TOP       ?= tbBranchPredict
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv) $(wildcard sim/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Overridable variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The trace path is relative to the project root, so run from here
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
hw/bpPkg.sv
hw/bpLinks.sv
hw/predictFetch.sv
hw/inflightQueue.sv
hw/branchResolve.sv
hw/branchPredictTop.sv
sim/tbBranchPredict.sv

// File: hw/bpLinks.sv
/*
 * Links between the fetch, queue and resolve blocks.
 * inflightIf moves a record when valid and ready are both high at a rising edge.
 */
`timescale 1ns/1ns
`default_nettype none

interface inflightIf;
    logic                        valid;
    logic                        ready;
    logic [bpPkg::XLEN-1:0]      pc;
    bpPkg::instrWord_u           instr;
    logic                        predTaken;
    logic [bpPkg::XLEN-1:0]      predTarget;
    logic [bpPkg::GHR_BITS-1:0]  phtIndex;

    modport source (output valid, pc, instr, predTaken, predTarget, phtIndex, input ready);
    modport sink (input valid, pc, instr, predTaken, predTarget, phtIndex, output ready);
endinterface

// Registered training pulses from resolve back to the tables
interface tableUpdateIf;
    logic                           phtWe;
    logic                           phtTaken;
    logic [bpPkg::GHR_BITS-1:0]     phtIndex;
    logic                           btbWe;
    logic [bpPkg::BTB_IDX_BITS-1:0] btbIndex;
    logic [bpPkg::XLEN-1:0]         btbTarget;
    logic                           ghrClear;

    modport source (output phtWe, phtTaken, phtIndex, btbWe, btbIndex, btbTarget, ghrClear);
    modport sink (input phtWe, phtTaken, phtIndex, btbWe, btbIndex, btbTarget, ghrClear);
endinterface

`default_nettype wire

// File: hw/bpPkg.sv
/*
 * Shared constants and the instruction word view for the branch predictor.
 * Only beq, bne and jal are treated as control flow; everything else is sequential.
 */
`default_nettype none

package bpPkg;

    localparam int XLEN         = 32;
    localparam int GHR_BITS     = 5;
    localparam int PHT_ENTRIES  = 32;
    localparam int BTB_ENTRIES  = 32;
    // Index taken from PC bits 6 down to 2
    localparam int BTB_IDX_BITS = 5;
    localparam int QUEUE_DEPTH  = 4;
    localparam int PTR_BITS     = 2;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [2:0] F3_BEQ    = 3'b000;
    localparam logic [2:0] F3_BNE    = 3'b001;

    localparam logic [XLEN-1:0] PC_STEP = 4;
    // Weakly not taken
    localparam logic [1:0] CTR_RESET = 2'b01;

    // One instruction word, read as B-type or J-type depending on opcode
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bView;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jView;
    } instrWord_u;

endpackage

`default_nettype wire

// File: hw/branchPredictTop.sv
/*
 * Single-slot branch prediction path: fetch prediction, in-flight queue, resolve.
 * resolveValid_i is only legal while resolveReady_o is high.
 */
`timescale 1ns/1ns
`default_nettype none

module branchPredictTop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetchValid_i,
    input  logic [bpPkg::XLEN-1:0] fetchPc_i,
    input  logic [bpPkg::XLEN-1:0] fetchInstr_i,
    output logic                   fetchReady_o,
    output logic                   predTaken_o,
    output logic [bpPkg::XLEN-1:0] predTarget_o,
    input  logic                   resolveValid_i,
    input  logic                   resolveZero_i,
    output logic                   resolveReady_o,
    output logic                   resolveDone_o,
    output logic                   mispredict_o,
    output logic [bpPkg::XLEN-1:0] redirectPc_o
);

    inflightIf    pushLink ();
    inflightIf    popLink ();
    tableUpdateIf updLink ();

    logic flush;

    predictFetch fetch0 (
        .clk          (clk),
        .reset        (reset),
        .fetchValid_i (fetchValid_i),
        .fetchPc_i    (fetchPc_i),
        .fetchInstr_i (fetchInstr_i),
        .predTaken_o  (predTaken_o),
        .predTarget_o (predTarget_o),
        .push         (pushLink.source),
        .update       (updLink.sink)
    );

    inflightQueue queue0 (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush),
        .push           (pushLink.sink),
        .pop            (popLink.source),
        .resolveReady_o (resolveReady_o),
        .fetchReady_o   (fetchReady_o)
    );

    branchResolve resolve0 (
        .clk            (clk),
        .reset          (reset),
        .resolveValid_i (resolveValid_i),
        .resolveZero_i  (resolveZero_i),
        .pop            (popLink.sink),
        .update         (updLink.source),
        .flush_o        (flush),
        .resolveDone_o  (resolveDone_o),
        .mispredict_o   (mispredict_o),
        .redirectPc_o   (redirectPc_o)
    );

endmodule

`default_nettype wire

// File: hw/branchResolve.sv
/*
 * Resolves the oldest queued prediction using the ALU zero flag.
 * All results and training pulses are registered, one cycle after the resolve.
 */
`timescale 1ns/1ns
`default_nettype none

module branchResolve (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   resolveValid_i,
    input  logic                   resolveZero_i,
    inflightIf.sink                pop,
    tableUpdateIf.source           update,
    output logic                   flush_o,
    output logic                   resolveDone_o,
    output logic                   mispredict_o,
    output logic [bpPkg::XLEN-1:0] redirectPc_o
);

    logic                   fire;
    logic                   isBranch;
    logic                   isJal;
    logic [2:0]             funct3;
    logic [bpPkg::XLEN-1:0] bImm;
    logic [bpPkg::XLEN-1:0] jImm;
    logic [bpPkg::XLEN-1:0] target;
    logic                   actualTaken;
    logic                   mispredictNow;

    assign pop.ready = resolveValid_i;
    assign fire      = pop.valid && pop.ready;

    assign isBranch = pop.instr.bView.opcode == bpPkg::OP_BRANCH;
    assign isJal    = pop.instr.jView.opcode == bpPkg::OP_JAL;
    assign funct3   = pop.instr.bView.funct3;

    // Sign-extended immediates with bit 0 always zero
    assign bImm = {{19{pop.instr.bView.imm12}}, pop.instr.bView.imm12,
                   pop.instr.bView.imm11, pop.instr.bView.imm10to5,
                   pop.instr.bView.imm4to1, 1'b0};
    assign jImm = {{11{pop.instr.jView.imm20}}, pop.instr.jView.imm20,
                   pop.instr.jView.imm19to12, pop.instr.jView.imm11,
                   pop.instr.jView.imm10to1, 1'b0};

    assign target = pop.pc + (isJal ? jImm : bImm);

    assign actualTaken = isJal ||
                         (isBranch && ((funct3 == bpPkg::F3_BEQ && resolveZero_i) ||
                                       (funct3 == bpPkg::F3_BNE && !resolveZero_i)));

    // Right direction can still go to a stale BTB target
    assign mispredictNow = (pop.predTaken != actualTaken) ||
                           (pop.predTaken && pop.predTarget != target);

    always_ff @(posedge clk) begin
        if (reset) begin
            resolveDone_o <= 1'b0;
            mispredict_o  <= 1'b0;
            update.phtWe  <= 1'b0;
            update.btbWe  <= 1'b0;
        end else begin
            resolveDone_o <= fire;
            mispredict_o  <= fire && mispredictNow;
            update.phtWe  <= fire && isBranch;
            update.btbWe  <= fire && actualTaken;
        end
    end

    // Payload that travels with the pulses
    always_ff @(posedge clk) begin
        redirectPc_o     <= actualTaken ? target : pop.pc + bpPkg::PC_STEP;
        update.phtTaken  <= actualTaken;
        update.phtIndex  <= pop.phtIndex;
        update.btbIndex  <= pop.pc[bpPkg::BTB_IDX_BITS+1:2];
        update.btbTarget <= target;
    end

    // Mispredict empties the queue and resets the history
    assign update.ghrClear = mispredict_o;
    assign flush_o         = mispredict_o;

    // No new resolve while the flush of a mispredict is still pending
    assert property (@(posedge clk) disable iff (reset) mispredict_o |-> !resolveValid_i);

    // Flush has emptied the queue by the following cycle
    assert property (@(posedge clk) disable iff (reset) mispredict_o |=> !pop.valid);

endmodule

`default_nettype wire

// File: hw/inflightQueue.sv
/*
 * Circular FIFO of predictions waiting for resolve in execute.
 * flush_i empties it completely and wins over a push in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module inflightQueue (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_i,
    inflightIf.sink   push,
    inflightIf.source pop,
    output logic      resolveReady_o,
    output logic      fetchReady_o
);

    logic [bpPkg::XLEN-1:0]     pcMem [bpPkg::QUEUE_DEPTH];
    bpPkg::instrWord_u          instrMem [bpPkg::QUEUE_DEPTH];
    logic                       takenMem [bpPkg::QUEUE_DEPTH];
    logic [bpPkg::XLEN-1:0]     targetMem [bpPkg::QUEUE_DEPTH];
    logic [bpPkg::GHR_BITS-1:0] phtIdxMem [bpPkg::QUEUE_DEPTH];

    logic [bpPkg::PTR_BITS-1:0] wrPtr;
    logic [bpPkg::PTR_BITS-1:0] rdPtr;
    logic [bpPkg::PTR_BITS:0]   count;
    logic                       full;
    logic                       empty;
    logic                       pushFire;
    logic                       popFire;

    assign full  = count == (bpPkg::PTR_BITS+1)'(bpPkg::QUEUE_DEPTH);
    assign empty = count == '0;

    assign push.ready     = !full;
    assign fetchReady_o   = !full;
    assign pop.valid      = !empty;
    assign resolveReady_o = !empty;

    assign pushFire = push.valid && push.ready;
    assign popFire  = pop.valid && pop.ready;

    // Oldest record is always at the read pointer
    assign pop.pc         = pcMem[rdPtr];
    assign pop.instr      = instrMem[rdPtr];
    assign pop.predTaken  = takenMem[rdPtr];
    assign pop.predTarget = targetMem[rdPtr];
    assign pop.phtIndex   = phtIdxMem[rdPtr];

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushFire) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popFire) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (pushFire && !popFire) begin
                count <= count + 1'b1;
            end else if (popFire && !pushFire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushFire) begin
            pcMem[wrPtr]     <= push.pc;
            instrMem[wrPtr]  <= push.instr;
            takenMem[wrPtr]  <= push.predTaken;
            targetMem[wrPtr] <= push.predTarget;
            phtIdxMem[wrPtr] <= push.phtIndex;
        end
    end

    // Resolve side must only ask for a record that exists
    assert property (@(posedge clk) disable iff (reset) pop.ready |-> !empty);

endmodule

`default_nettype wire

// File: hw/predictFetch.sv
/*
 * Gshare direction predictor with an untagged direct-mapped BTB.
 * Prediction is combinational; only beq/bne/jal fetches are pushed to the queue.
 */
`timescale 1ns/1ns
`default_nettype none

module predictFetch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetchValid_i,
    input  logic [bpPkg::XLEN-1:0] fetchPc_i,
    input  logic [bpPkg::XLEN-1:0] fetchInstr_i,
    output logic                   predTaken_o,
    output logic [bpPkg::XLEN-1:0] predTarget_o,
    inflightIf.source              push,
    tableUpdateIf.sink             update
);

    logic [bpPkg::GHR_BITS-1:0]     ghr;
    logic [1:0]                     pht [bpPkg::PHT_ENTRIES];
    logic                           btbValid [bpPkg::BTB_ENTRIES];
    logic [bpPkg::XLEN-1:0]         btbTarget [bpPkg::BTB_ENTRIES];

    bpPkg::instrWord_u              fetchWord;
    logic [bpPkg::GHR_BITS-1:0]     phtIdx;
    logic [bpPkg::BTB_IDX_BITS-1:0] btbIdx;
    logic                           isBranch;
    logic                           isJal;
    logic                           pushFire;

    assign fetchWord.raw = fetchInstr_i;
    assign isBranch = fetchWord.bView.opcode == bpPkg::OP_BRANCH;
    assign isJal    = fetchWord.jView.opcode == bpPkg::OP_JAL;

    // Gshare index folds the history onto the word address
    assign phtIdx = ghr ^ fetchPc_i[bpPkg::GHR_BITS+1:2];
    assign btbIdx = fetchPc_i[bpPkg::BTB_IDX_BITS+1:2];

    // Without a BTB hit there is no target to jump to
    assign predTaken_o = btbValid[btbIdx] && (isJal || (isBranch && pht[phtIdx][1]));
    assign predTarget_o = predTaken_o ? btbTarget[btbIdx] : fetchPc_i + bpPkg::PC_STEP;

    assign push.valid      = fetchValid_i && (isBranch || isJal);
    assign push.pc         = fetchPc_i;
    assign push.instr      = fetchWord;
    assign push.predTaken  = predTaken_o;
    assign push.predTarget = predTarget_o;
    assign push.phtIndex   = phtIdx;

    assign pushFire = push.valid && push.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < bpPkg::PHT_ENTRIES; i++) begin
                pht[i] <= bpPkg::CTR_RESET;
            end
            for (int i = 0; i < bpPkg::BTB_ENTRIES; i++) begin
                btbValid[i] <= 1'b0;
            end
        end else begin
            // Mispredict clear beats the speculative shift
            if (update.ghrClear) begin
                ghr <= '0;
            end else if (pushFire && isBranch) begin
                ghr <= {ghr[bpPkg::GHR_BITS-2:0], predTaken_o};
            end

            // Saturating 2-bit counters
            if (update.phtWe) begin
                if (update.phtTaken && pht[update.phtIndex] != 2'b11) begin
                    pht[update.phtIndex] <= pht[update.phtIndex] + 2'b01;
                end else if (!update.phtTaken && pht[update.phtIndex] != 2'b00) begin
                    pht[update.phtIndex] <= pht[update.phtIndex] - 2'b01;
                end
            end

            if (update.btbWe) begin
                btbValid[update.btbIndex] <= 1'b1;
            end
        end
    end

    // Target storage is qualified by btbValid
    always_ff @(posedge clk) begin
        if (update.btbWe) begin
            btbTarget[update.btbIndex] <= update.btbTarget;
        end
    end

endmodule

`default_nettype wire

// File: sim/branch_trace.txt
# One command per line, all numbers in hex
# F pc instr expFetchReady expPredTaken expPredTarget
# R zeroFlag expMispredict expRedirectPc
# I expResolveReady expFetchReady

# Out of reset, then a cold beq
I 0 1
F 00000100 00208863 1 0 00000104
R 0 0 00000104
# beq +16 at 0x108, first taken resolve mispredicts
F 00000108 00208863 1 0 0000010C
R 1 1 00000118
I 0 1
# Second taken resolve at the same history
F 00000108 00208863 1 1 00000118
R 1 0 00000118
# Cold jal +0x100 mispredicts, then hits in the BTB
F 00000204 100000EF 1 0 00000208
R 0 1 00000304
F 00000204 100000EF 1 1 00000304
R 0 0 00000304
# History cleared, trained beq predicts taken but falls through
F 00000108 00208863 1 1 00000118
R 0 1 0000010C
I 0 1
# Four branches fill the queue
F 00000140 00208863 1 0 00000144
F 00000144 00208863 1 0 00000148
F 00000148 00208863 1 0 0000014C
F 0000014C 00208863 1 0 00000150
F 00000150 00208863 0 0 00000154
I 1 0
R 0 0 00000144
I 1 1
# Taken resolve of a queued branch flushes the rest
R 1 1 00000154
I 0 1
# bne -8 after the flush pairs with the next resolve
F 00000160 FE209CE3 1 0 00000164
R 0 1 00000158
# addi is sequential and never queued
F 00000170 00100093 1 0 00000174
I 0 1
F 00000160 FE209CE3 1 1 00000158
R 1 1 00000164
I 0 1

// File: sim/tbBranchPredict.sv
/*
 * Trace-driven testbench for branchPredictTop; run from the project root.
 * Trace commands: F fetch, R resolve, I idle; all fields in hex.
 */
`timescale 1ns/1ns
`default_nettype none

module tbBranchPredict;

    localparam string TRACE_PATH      = "sim/branch_trace.txt";
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    DONE_WAIT_LIMIT = 4;

    logic                   clk;
    logic                   reset;
    logic                   fetchValid_i;
    logic [bpPkg::XLEN-1:0] fetchPc_i;
    logic [bpPkg::XLEN-1:0] fetchInstr_i;
    logic                   fetchReady_o;
    logic                   predTaken_o;
    logic [bpPkg::XLEN-1:0] predTarget_o;
    logic                   resolveValid_i;
    logic                   resolveZero_i;
    logic                   resolveReady_o;
    logic                   resolveDone_o;
    logic                   mispredict_o;
    logic [bpPkg::XLEN-1:0] redirectPc_o;

    string traceLines [$];
    int    traceLineNos [$];
    int    valueErrors;
    int    otherErrors;
    int    cycleCount;
    int    cycleLimit;
    int    currentLine;
    bit    traceOk;

    branchPredictTop dut0 (
        .clk            (clk),
        .reset          (reset),
        .fetchValid_i   (fetchValid_i),
        .fetchPc_i      (fetchPc_i),
        .fetchInstr_i   (fetchInstr_i),
        .fetchReady_o   (fetchReady_o),
        .predTaken_o    (predTaken_o),
        .predTarget_o   (predTarget_o),
        .resolveValid_i (resolveValid_i),
        .resolveZero_i  (resolveZero_i),
        .resolveReady_o (resolveReady_o),
        .resolveDone_o  (resolveDone_o),
        .mispredict_o   (mispredict_o),
        .redirectPc_o   (redirectPc_o)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Limit stays at zero until the trace length is known
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: the trace did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = 0x%h, expected 0x%h (trace line %0d)",
                     name, actual, expected, currentLine);
            valueErrors++;
        end
    endtask

    task automatic driveIdle();
        fetchValid_i   = 1'b0;
        fetchPc_i      = '0;
        fetchInstr_i   = '0;
        resolveValid_i = 1'b0;
        resolveZero_i  = 1'b0;
    endtask

    task automatic reportMalformed(input int fields);
        $display("Trace line %0d is malformed, it needs %0d fields", currentLine, fields);
        otherErrors++;
    endtask

    // Keeps command lines only, with their line numbers for messages
    task automatic loadTrace(output bit ok);
        int    fd;
        int    lineNo;
        string line;
        byte   first;
        fd = $fopen(TRACE_PATH, "r");
        ok = (fd != 0);
        if (ok) begin
            lineNo = 0;
            while ($fgets(line, fd) != 0) begin
                lineNo++;
                if (line.len() > 1) begin
                    first = line.getc(0);
                    if (first >= "A" && first <= "Z") begin
                        traceLines.push_back(line);
                        traceLineNos.push_back(lineNo);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Prediction is combinational, so it is checked in the same cycle
    task automatic fetchCommand(input string line);
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] expReady;
        logic [31:0] expTaken;
        logic [31:0] expTarget;
        int          n;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h",
                    pc, instr, expReady, expTaken, expTarget);
        if (n != 5) begin
            reportMalformed(5);
        end else begin
            driveIdle();
            fetchValid_i = 1'b1;
            fetchPc_i    = pc;
            fetchInstr_i = instr;
            #1;
            checkValue("fetchReady_o", 32'(fetchReady_o), expReady);
            checkValue("predTaken_o", 32'(predTaken_o), expTaken);
            checkValue("predTarget_o", predTarget_o, expTarget);
            @(negedge clk);
        end
    endtask

    task automatic resolveCommand(input string line);
        logic [31:0] zero;
        logic [31:0] expMispredict;
        logic [31:0] expRedirect;
        int          n;
        int          waited;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                    zero, expMispredict, expRedirect);
        if (n != 3) begin
            reportMalformed(3);
        end else begin
            driveIdle();
            resolveValid_i = 1'b1;
            resolveZero_i  = zero[0];
            #1;
            // A resolve is only legal with a record waiting
            checkValue("resolveReady_o", 32'(resolveReady_o), 32'd1);
            @(negedge clk);
            driveIdle();
            #1;
            waited = 0;
            while (resolveDone_o !== 1'b1 && waited < DONE_WAIT_LIMIT) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (resolveDone_o !== 1'b1) begin
                $display("resolveDone_o never pulsed after the resolve on trace line %0d",
                         currentLine);
                otherErrors++;
            end else begin
                if (waited != 0) begin
                    $display("resolveDone_o came %0d cycles late on trace line %0d",
                             waited, currentLine);
                    otherErrors++;
                end
                checkValue("mispredict_o", 32'(mispredict_o), expMispredict);
                checkValue("redirectPc_o", redirectPc_o, expRedirect);
            end
            // Table update and flush land at the next edge
            @(negedge clk);
        end
    endtask

    task automatic idleCommand(input string line);
        logic [31:0] expResolveReady;
        logic [31:0] expFetchReady;
        int          n;
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", expResolveReady, expFetchReady);
        if (n != 2) begin
            reportMalformed(2);
        end else begin
            driveIdle();
            #1;
            checkValue("resolveReady_o", 32'(resolveReady_o), expResolveReady);
            checkValue("fetchReady_o", 32'(fetchReady_o), expFetchReady);
            checkValue("resolveDone_o", 32'(resolveDone_o), 32'd0);
            checkValue("mispredict_o", 32'(mispredict_o), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic runCommand(input string line);
        case (line.getc(0))
            "F": fetchCommand(line);
            "R": resolveCommand(line);
            "I": idleCommand(line);
            default: begin
                $display("Unknown command on trace line %0d", currentLine);
                otherErrors++;
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        currentLine = 0;
        driveIdle();
        loadTrace(traceOk);
        if (!traceOk) begin
            $display("Could not open the trace file %s", TRACE_PATH);
            $display("TB FAILED");
            $finish;
        end else begin
            if (traceLines.size() == 0) begin
                $display("The trace file holds no commands");
                otherErrors++;
            end
            cycleLimit = CYCLES_PER_LINE * traceLines.size();
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            foreach (traceLines[i]) begin
                currentLine = traceLineNos[i];
                runCommand(traceLines[i]);
            end
            $display("Summary: %0d value errors, %0d other errors, %0d trace commands",
                     valueErrors, otherErrors, traceLines.size());
            if (valueErrors == 0 && otherErrors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
